//--- Bender.yml
package:
  name: fetch_stage

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_pc_ctrl.sv
      - hdl/branch_predictor.sv
      - hdl/fetch_cmd_queue.sv
      - hdl/fetch_top.sv
  - target: test
    files:
      - dv/fetch_props.sv
      - dv/fetch_tb.sv

//--- dv/fetch_props.sv
module fetch_props
    import fetch_pkg::*;
#(
    parameter logic [xlen-1:0] start_addr = '0
) (
    input logic            clk,
    input logic            rst_n,
    input logic            jump_valid,
    input logic            jump_ready,
    input logic            jump_update_pc,
    input logic            jump_halt,
    input logic [xlen-1:0] jump_actual_next_pc,
    input logic            mem_valid,
    input logic            mem_ready,
    input logic [xlen-1:0] mem_addr,
    input logic            cmd_valid,
    input logic            cmd_ready,
    input logic [xlen-1:0] cmd_pc,
    input logic [xlen-1:0] cmd_next_pc,
    input bp_counter_t     cmd_history
);

    timeunit 1ns;
    timeprecision 1ps;

    int              err_count = 0;
    logic            mem_fire;
    logic            cmd_fire;
    logic            jump_kill;
    // Addresses transferred to memory whose commands have not left yet.
    logic [xlen-1:0] addr_log [2];
    logic [1:0]      log_cnt;
    logic            started;
    logic            redirect_pend;
    logic [xlen-1:0] redirect_addr;
    logic            halted;
    logic            xfer_ok;
    logic            order_ok;

    assign mem_fire  = mem_valid && mem_ready;
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign jump_kill = jump_valid && jump_ready && (jump_update_pc || jump_halt);

    always_comb begin
        xfer_ok = 1'b1;
        if (mem_fire && !started) begin
            xfer_ok = mem_addr == start_addr;
        end
        if (mem_fire && redirect_pend) begin
            xfer_ok = mem_addr == redirect_addr;
        end
        order_ok = 1'b1;
        if (cmd_fire) begin
            order_ok = cmd_pc == addr_log[0];
            if (log_cnt == 2'd2) begin
                order_ok = order_ok && (cmd_next_pc == addr_log[1]);
            end else if (mem_fire) begin
                order_ok = order_ok && (cmd_next_pc == mem_addr);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            log_cnt       <= 2'd0;
            started       <= 1'b0;
            redirect_pend <= 1'b0;
            halted        <= 1'b0;
        end else begin
            if (mem_fire) begin
                started <= 1'b1;
            end
            if (cmd_fire) begin
                addr_log[0] <= addr_log[1];
            end
            if (jump_kill) begin
                log_cnt       <= 2'd0;
                redirect_pend <= !jump_halt;
                redirect_addr <= jump_actual_next_pc;
                halted        <= halted || jump_halt;
            end else begin
                if (mem_fire) begin
                    addr_log[log_cnt[0] & ~cmd_fire] <= mem_addr;
                    redirect_pend                    <= 1'b0;
                end
                log_cnt <= log_cnt + 2'(mem_fire) - 2'(cmd_fire);
            end
        end
    end

    // Quiet in reset and in the cycle it ends.
    assert property (@(posedge clk) !rst_n || $rose(rst_n) |-> !mem_valid && !cmd_valid)
        else begin
            $error("request or command offered during reset");
            err_count++;
        end

    // Jumps are taken in every cycle after reset.
    assert property (@(posedge clk) disable iff (!rst_n) $past(rst_n) |-> jump_ready)
        else begin
            $error("jump command not accepted after reset");
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ready |=> jump_kill || (mem_valid && $stable(mem_addr)))
        else begin
            $error("memory request changed while stalled");
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready && !jump_kill |=>
            cmd_valid && $stable(cmd_pc) && $stable(cmd_next_pc) && $stable(cmd_history))
        else begin
            $error("instruction command changed while stalled");
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) xfer_ok)
        else begin
            $error("fetch address after reset or redirect is wrong");
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        order_ok && (cmd_valid == (log_cnt != 2'd0)))
        else begin
            $error("command out of order or not matching the fetch stream");
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) halted |-> !mem_valid && !cmd_valid)
        else begin
            $error("fetch active after halt");
            err_count++;
        end

endmodule

bind fetch_top fetch_props #(.start_addr(start_addr)) props (.*);

//--- dv/fetch_tb.sv
module fetch_tb
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [xlen-1:0] start_addr = '0;
    localparam int period        = 10;
    localparam int reset_cycles  = 8;
    localparam int free_cycles   = 60;
    localparam int stall_cycles  = 120;
    localparam int settle_cycles = 40;
    // Phases 3 to 5 take about settle_cycles each.
    localparam int budget_cycles = reset_cycles + free_cycles + stall_cycles
                                   + 3 * settle_cycles + 100;

    logic            clk;
    logic            rst_n;
    logic            jump_valid;
    logic            jump_ready;
    logic            jump_update_pc;
    logic            jump_branched;
    logic            jump_halt;
    logic [xlen-1:0] jump_current_pc;
    logic [xlen-1:0] jump_actual_next_pc;
    logic            mem_valid;
    logic            mem_ready;
    logic [xlen-1:0] mem_addr;
    logic            cmd_valid;
    logic            cmd_ready;
    logic [xlen-1:0] cmd_pc;
    logic [xlen-1:0] cmd_next_pc;
    bp_counter_t     cmd_history;
    bp_counter_t     trained_state;
    logic [15:0]     lfsr = 16'd34030;
    logic            random_ready;

    fetch_top #(
        .start_addr(start_addr),
        .target_addr_width(5),
        .local_addr_width(7)
    ) DUT (
        .clk, .rst_n,
        .jump_valid, .jump_ready, .jump_update_pc, .jump_branched,
        .jump_jumped(1'b0), .jump_halt, .jump_miss(1'b1),
        .jump_current_pc, .jump_actual_next_pc, .jump_history(weak_not_taken),
        .mem_valid, .mem_ready, .mem_addr,
        .cmd_valid, .cmd_ready, .cmd_pc, .cmd_next_pc, .cmd_history
    );

    function automatic logic lfsr_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    task automatic fail_run(string msg);
        $display("error at %0t: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, msg);
    endtask

    task automatic run_cycles(int n);
        repeat (n) begin
            @(negedge clk);
            jump_valid = 1'b0;
            mem_ready  = random_ready ? lfsr_bit() : 1'b1;
            cmd_ready  = random_ready ? lfsr_bit() : 1'b1;
        end
    endtask

    task automatic send_jump(logic update_pc, logic branched, logic halt,
                             logic [xlen-1:0] current_pc, logic [xlen-1:0] next_pc);
        run_cycles(1);
        jump_valid          = 1'b1;
        jump_update_pc      = update_pc;
        jump_branched       = branched;
        jump_halt           = halt;
        jump_current_pc     = current_pc;
        jump_actual_next_pc = next_pc;
    endtask

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        wait (DUT.props.err_count != 0);
        fail_run("assertion in fetch_props failed");
    end

    initial begin
        #(budget_cycles * period);
        $display("Watchdog expired, the test did not finish in %0d cycles", budget_cycles);
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        rst_n               = 1'b0;
        jump_valid          = 1'b0;
        jump_update_pc      = 1'b0;
        jump_branched       = 1'b0;
        jump_halt           = 1'b0;
        jump_current_pc     = '0;
        jump_actual_next_pc = '0;
        mem_ready           = 1'b0;
        cmd_ready           = 1'b0;
        random_ready        = 1'b0;
        // Two taken steps from the reset state, capped at the top.
        trained_state = (int'(weak_not_taken) + 2 > int'(strong_taken)) ? strong_taken :
                        bp_counter_t'(int'(weak_not_taken) + 2);
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        run_cycles(free_cycles);
        random_ready = 1'b1;
        run_cycles(stall_cycles);
        send_jump(1'b1, 1'b0, 1'b0, mem_addr, 32'h200);
        run_cycles(settle_cycles);

        // Train pc 8 toward 64, then fetch it again from 0.
        send_jump(1'b0, 1'b1, 1'b0, 32'd8, 32'd64);
        send_jump(1'b0, 1'b1, 1'b0, 32'd8, 32'd64);
        run_cycles(10);
        random_ready = 1'b0;
        send_jump(1'b1, 1'b0, 1'b0, mem_addr, 32'd0);
        do begin
            run_cycles(1);
            #1;
        end while (!(cmd_valid && cmd_ready && cmd_pc == 32'd8));
        assert (cmd_next_pc == 32'd64 && cmd_history == trained_state)
            else fail_run($sformatf("pc 8 predicted next %0h with history %s",
                                    cmd_next_pc, cmd_history.name()));
        while (!(mem_valid && mem_ready)) begin
            run_cycles(1);
            #1;
        end
        assert (mem_addr == 32'd64)
            else fail_run($sformatf("fetch after trained pc 8 went to %0h", mem_addr));

        random_ready = 1'b1;
        send_jump(1'b0, 1'b0, 1'b1, mem_addr, 32'd0);
        run_cycles(settle_cycles);

        if (DUT.props.err_count != 0) begin
            fail_run("assertion failures counted at the end of the run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- hdl/branch_predictor.sv
module branch_predictor
    import fetch_pkg::*;
#(
    parameter int unsigned target_addr_width = 5,
    parameter int unsigned local_addr_width  = 7
) (
    input  logic            clk,
    input  logic            rst_n,

    input  logic [xlen-1:0] lookup_pc,
    output logic [xlen-1:0] pred_next_pc,
    output bp_counter_t     pred_history,

    input  logic            train_valid,
    input  logic [xlen-1:0] train_pc,
    input  logic [xlen-1:0] train_target,
    input  logic            train_taken
);

    localparam int unsigned tag_width     = xlen - target_addr_width - 2;
    localparam int unsigned local_entries = 2 ** local_addr_width;
    localparam int unsigned btb_entries   = 2 ** target_addr_width;

    bp_counter_t                   counters [local_entries];
    logic [btb_entries-1:0]        btb_valid;
    logic [tag_width-1:0]          btb_tag [btb_entries];
    logic [xlen-1:0]               btb_target [btb_entries];

    logic [local_addr_width-1:0]   lookup_local_idx;
    logic [local_addr_width-1:0]   train_local_idx;
    logic [target_addr_width-1:0]  lookup_btb_idx;
    logic [target_addr_width-1:0]  train_btb_idx;
    logic [tag_width-1:0]          lookup_tag;
    logic [tag_width-1:0]          train_tag;
    bp_counter_t                   lookup_counter;
    logic                          btb_hit;

    // Instructions are word aligned, so bits 1:0 are skipped.
    assign lookup_local_idx = lookup_pc[local_addr_width+1:2];
    assign train_local_idx  = train_pc[local_addr_width+1:2];
    assign lookup_btb_idx   = lookup_pc[target_addr_width+1:2];
    assign train_btb_idx    = train_pc[target_addr_width+1:2];
    assign lookup_tag       = lookup_pc[xlen-1:target_addr_width+2];
    assign train_tag        = train_pc[xlen-1:target_addr_width+2];

    assign lookup_counter = counters[lookup_local_idx];
    assign btb_hit        = btb_valid[lookup_btb_idx] &&
                            (btb_tag[lookup_btb_idx] == lookup_tag);

    assign pred_history = lookup_counter;

    always_comb begin
        if (btb_hit && counter_taken(lookup_counter)) begin
            pred_next_pc = btb_target[lookup_btb_idx];
        end else begin
            pred_next_pc = lookup_pc + xlen'(4);
        end
    end

    // Counters start weakly not taken.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < local_entries; i++) begin
                counters[i] <= weak_not_taken;
            end
        end else if (train_valid) begin
            counters[train_local_idx] <= counter_step(counters[train_local_idx], train_taken);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btb_valid <= '0;
        end else if (train_valid && train_taken) begin
            btb_valid[train_btb_idx] <= 1'b1;
        end
    end

    // Only taken outcomes fill the target buffer.
    always_ff @(posedge clk) begin
        if (train_valid && train_taken) begin
            btb_tag[train_btb_idx]    <= train_tag;
            btb_target[train_btb_idx] <= train_target;
        end
    end

endmodule

//--- hdl/fetch_cmd_queue.sv
module fetch_cmd_queue
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  logic            push,
    input  logic [xlen-1:0] push_pc,
    input  logic [xlen-1:0] push_next_pc,
    input  bp_counter_t     push_history,
    input  logic            flush,
    output logic            not_full,

    output logic            cmd_valid,
    input  logic            cmd_ready,
    output logic [xlen-1:0] cmd_pc,
    output logic [xlen-1:0] cmd_next_pc,
    output bp_counter_t     cmd_history
);

    logic [xlen-1:0] pc_mem [2];
    logic [xlen-1:0] next_pc_mem [2];
    bp_counter_t     history_mem [2];
    logic [1:0]      count_q;
    logic [1:0]      fill;
    logic            pop;
    logic            push_en;

    // Entry 0 is always the head, so the outputs come straight from registers.
    assign cmd_valid   = count_q != 2'd0;
    assign cmd_pc      = pc_mem[0];
    assign cmd_next_pc = next_pc_mem[0];
    assign cmd_history = history_mem[0];
    assign not_full    = count_q != 2'd2;

    assign pop     = cmd_valid && cmd_ready;
    assign push_en = push && !flush;
    assign fill    = count_q - {1'b0, pop};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= 2'd0;
        end else if (flush) begin
            count_q <= 2'd0;
        end else begin
            count_q <= fill + {1'b0, push_en};
        end
    end

    // Shift on pop first, then the push lands behind what remains.
    always_ff @(posedge clk) begin
        if (pop) begin
            pc_mem[0]      <= pc_mem[1];
            next_pc_mem[0] <= next_pc_mem[1];
            history_mem[0] <= history_mem[1];
        end
        if (push_en) begin
            pc_mem[fill[0]]      <= push_pc;
            next_pc_mem[fill[0]] <= push_next_pc;
            history_mem[fill[0]] <= push_history;
        end
    end

endmodule

//--- hdl/fetch_pc_ctrl.sv
module fetch_pc_ctrl
    import fetch_pkg::*;
#(
    parameter logic [xlen-1:0] start_addr = '0
) (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            jump_valid,
    output logic            jump_ready,
    input  logic            jump_update_pc,
    input  logic            jump_branched,
    input  logic            jump_jumped,
    input  logic            jump_halt,
    input  logic            jump_miss,
    input  logic [xlen-1:0] jump_current_pc,
    input  logic [xlen-1:0] jump_actual_next_pc,
    input  bp_counter_t     jump_history,

    output logic            mem_valid,
    input  logic            mem_ready,
    output logic [xlen-1:0] mem_addr,

    output logic [xlen-1:0] lookup_pc,
    input  logic [xlen-1:0] pred_next_pc,
    input  bp_counter_t     pred_history,

    output logic            push,
    output logic [xlen-1:0] push_pc,
    output logic [xlen-1:0] push_next_pc,
    output bp_counter_t     push_history,
    input  logic            not_full,
    output logic            flush,

    output logic            train_valid,
    output logic [xlen-1:0] train_pc,
    output logic [xlen-1:0] train_target,
    output logic            train_taken
);

    logic            active_q;
    logic            halted_q;
    logic [xlen-1:0] pc_q;
    logic            jump_accept;
    jump_op_t        jump_op;
    logic            train_needed;
    logic            mem_fire;

    assign jump_ready  = active_q;
    assign jump_accept = jump_valid && jump_ready;

    // Halt wins over redirect, redirect over plain training.
    always_comb begin
        jump_op = op_none;
        if (jump_accept) begin
            if (jump_halt) begin
                jump_op = op_halt;
            end else if (jump_update_pc) begin
                jump_op = op_redirect;
            end else if (jump_branched || jump_jumped) begin
                jump_op = op_train;
            end
        end
    end

    assign flush = (jump_op == op_redirect) || (jump_op == op_halt);

    // A request in the same cycle as a redirect or halt is withdrawn.
    assign mem_valid = active_q && !halted_q && not_full && !flush;
    assign mem_addr  = pc_q;
    assign mem_fire  = mem_valid && mem_ready;
    assign lookup_pc = pc_q;

    assign push         = mem_fire;
    assign push_pc      = pc_q;
    assign push_next_pc = pred_next_pc;
    assign push_history = pred_history;

    assign train_pc     = jump_current_pc;
    assign train_target = jump_actual_next_pc;
    assign train_taken  = jump_actual_next_pc != jump_current_pc + xlen'(4);

    // A correct prediction from a saturated counter has nothing left to learn.
    assign train_needed = jump_miss || !counter_saturated(jump_history, train_taken);
    assign train_valid  = jump_accept && (jump_branched || jump_jumped) && train_needed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            halted_q <= 1'b0;
            pc_q     <= start_addr;
        end else begin
            active_q <= 1'b1;
            if (jump_op == op_halt) begin
                halted_q <= 1'b1;
            end
            if (jump_op == op_redirect) begin
                pc_q <= jump_actual_next_pc;
            end else if (mem_fire) begin
                pc_q <= pred_next_pc;
            end
        end
    end

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

    localparam int unsigned xlen = 32;

    // Two-bit saturating counter, ordered so that the upper half predicts taken.
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } bp_counter_t;

    // What an accepted jump command asks of the fetch stage.
    typedef enum logic [1:0] {
        op_none,
        op_train,
        op_redirect,
        op_halt
    } jump_op_t;

    function automatic logic counter_taken(bp_counter_t state);
        return state inside {weak_taken, strong_taken};
    endfunction

    // True when a step toward the outcome would leave the counter unchanged.
    function automatic logic counter_saturated(bp_counter_t state, logic taken);
        return taken ? (state == strong_taken) : (state == strong_not_taken);
    endfunction

    function automatic bp_counter_t counter_step(bp_counter_t state, logic taken);
        bp_counter_t next_state;
        next_state = state;
        if (taken) begin
            if (state != strong_taken) begin
                next_state = bp_counter_t'(state + 2'd1);
            end
        end else begin
            if (state != strong_not_taken) begin
                next_state = bp_counter_t'(state - 2'd1);
            end
        end
        return next_state;
    endfunction

endpackage

//--- hdl/fetch_top.sv
module fetch_top
    import fetch_pkg::*;
#(
    parameter logic [xlen-1:0] start_addr        = '0,
    parameter int unsigned     target_addr_width = 5,
    parameter int unsigned     local_addr_width  = 7
) (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            jump_valid,
    output logic            jump_ready,
    input  logic            jump_update_pc,
    input  logic            jump_branched,
    input  logic            jump_jumped,
    input  logic            jump_halt,
    input  logic            jump_miss,
    input  logic [xlen-1:0] jump_current_pc,
    input  logic [xlen-1:0] jump_actual_next_pc,
    input  bp_counter_t     jump_history,

    output logic            mem_valid,
    input  logic            mem_ready,
    output logic [xlen-1:0] mem_addr,

    output logic            cmd_valid,
    input  logic            cmd_ready,
    output logic [xlen-1:0] cmd_pc,
    output logic [xlen-1:0] cmd_next_pc,
    output bp_counter_t     cmd_history
);

    logic [xlen-1:0] lookup_pc;
    logic [xlen-1:0] pred_next_pc;
    bp_counter_t     pred_history;
    logic            push;
    logic [xlen-1:0] push_pc;
    logic [xlen-1:0] push_next_pc;
    bp_counter_t     push_history;
    logic            not_full;
    logic            flush;
    logic            train_valid;
    logic [xlen-1:0] train_pc;
    logic [xlen-1:0] train_target;
    logic            train_taken;

    fetch_pc_ctrl #(
        .start_addr(start_addr)
    ) pc_ctrl (
        .clk, .rst_n,
        .jump_valid, .jump_ready, .jump_update_pc, .jump_branched,
        .jump_jumped, .jump_halt, .jump_miss,
        .jump_current_pc, .jump_actual_next_pc, .jump_history,
        .mem_valid, .mem_ready, .mem_addr,
        .lookup_pc, .pred_next_pc, .pred_history,
        .push, .push_pc, .push_next_pc, .push_history,
        .not_full, .flush,
        .train_valid, .train_pc, .train_target, .train_taken
    );

    branch_predictor #(
        .target_addr_width(target_addr_width),
        .local_addr_width(local_addr_width)
    ) predictor (
        .clk, .rst_n,
        .lookup_pc, .pred_next_pc, .pred_history,
        .train_valid, .train_pc, .train_target, .train_taken
    );

    fetch_cmd_queue cmd_queue (
        .clk, .rst_n,
        .push, .push_pc, .push_next_pc, .push_history,
        .flush, .not_full,
        .cmd_valid, .cmd_ready, .cmd_pc, .cmd_next_pc, .cmd_history
    );

endmodule

//--- list.f
hdl/fetch_pkg.sv
hdl/fetch_pc_ctrl.sv
hdl/branch_predictor.sv
hdl/fetch_cmd_queue.sv
hdl/fetch_top.sv
dv/fetch_props.sv
dv/fetch_tb.sv
